// ==== vlog.f ====
+incdir+include
verilog/dmiss_pkg.sv
verilog/dmiss_ifs.sv
verilog/dmiss_port_filter.sv
verilog/dmiss_alloc.sv
verilog/dmiss_entries.sv
verilog/dmiss_replay.sv
verilog/dmiss_cam_top.sv
bench/dmiss_checker.sv
bench/dmiss_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dmiss_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Test OK" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/dmiss_tb.sv ====
`timescale 1ns/1ps
`include "dmiss_settings.svh"

module dmiss_tb;

  localparam int OP_FILL    = 0;
  localparam int OP_IDLE    = 1;
  localparam int OP_REFILL  = 2;
  localparam int OP_READ    = 3;
  localparam int OP_FLAGS   = 4;
  localparam int OP_REPLAY  = 5;
  localparam int OP_UNLOCK  = 6;
  localparam int OP_END     = 7;
  localparam int POOL_SIZE  = 24;
  localparam int WAIT_LIMIT = 40; // cycles allowed for each wait

  logic                                     clk;
  logic                                     rst;
  dmiss_pkg::port_mask_t                    fill_en_i;
  dmiss_pkg::line_addr_t [`DMISS_PORTS-1:0] fill_addr_i;
  dmiss_pkg::port_mask_t                    fill_st_i;
  dmiss_pkg::op_size_t   [`DMISS_PORTS-1:0] fill_sz_i;
  logic                                     ins_en_i;
  dmiss_pkg::entry_idx_t                    ins_idx_i;
  logic                                     unlock_i;
  dmiss_pkg::line_addr_t                    ins_addr_o;
  logic                                     has_free_o;
  logic                                     locked_o;
  logic                                     begin_replay_o;
  logic                                     read_en_o;
  dmiss_pkg::line_addr_t                    read_addr_o;
  logic                                     read_st_o;
  dmiss_pkg::op_size_t                      read_sz_o;
  logic                                     timed_out;

  dmiss_pkg::line_addr_t addr_pool [POOL_SIZE];
  logic                  st_pool   [POOL_SIZE][2]; // payload differs per port
  dmiss_pkg::op_size_t   sz_pool   [POOL_SIZE][2];

  string row_name [$];
  int    row_op   [$];
  int    row_a0   [$]; // pool index for port 0 or the expected address, -1 for none
  int    row_a1   [$];
  int    row_arg  [$]; // entry index, source port, or {has_free, locked}

  dmiss_cam_top uut (.*);

  dmiss_checker chk (
    .clk            (clk),
    .rst            (rst),
    .ins_en_i       (ins_en_i),
    .ins_addr_i     (ins_addr_o),
    .has_free_i     (has_free_o),
    .locked_i       (locked_o),
    .begin_replay_i (begin_replay_o),
    .read_en_i      (read_en_o),
    .read_addr_i    (read_addr_o),
    .read_st_i      (read_st_o),
    .read_sz_i      (read_sz_o)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic add_row(input string name, input int op, input int a0, input int a1,
                         input int arg);
    row_name.push_back(name);
    row_op.push_back(op);
    row_a0.push_back(a0);
    row_a1.push_back(a1);
    row_arg.push_back(arg);
  endtask

  task automatic add_idle(input string name, input int n);
    for (int c = 0; c < n; c++) begin
      add_row(name, OP_IDLE, 0, 0, 0);
    end
  endtask

  // every test ends with a readout and an unlock
  task automatic add_tail(input string name);
    add_row(name, OP_REPLAY, 0, 0, 0);
    add_row(name, OP_UNLOCK, 0, 0, 0);
    add_row(name, OP_END, 0, 0, 0);
  endtask

  task automatic build_table();
    string t;
    t = "single_miss";
    add_row(t, OP_FILL, 0, -1, 0);
    add_idle(t, 2);
    add_row(t, OP_REFILL, 0, 0, 0);
    add_row(t, OP_READ, 0, 0, 0);
    add_tail(t);
    t = "same_cycle_dup";
    add_row(t, OP_FILL, 1, 1, 0);
    add_idle(t, 2);
    add_row(t, OP_REFILL, -1, 0, 1); // entry 1 must stay idle
    add_row(t, OP_REFILL, 1, 0, 0);
    add_row(t, OP_READ, 1, 0, 1);    // port 1 keeps the miss
    add_tail(t);
    t = "history_dup";
    for (int c = 0; c < 3; c++) begin
      add_row(t, OP_FILL, 2 + 2 * c, 3 + 2 * c, 0);
    end
    add_row(t, OP_FILL, 8, -1, 0);
    add_idle(t, 2);
    add_row(t, OP_FILL, -1, 2, 0);   // same line as entry 0
    add_idle(t, 1);
    add_row(t, OP_FLAGS, 0, 0, 2);
    add_row(t, OP_REFILL, -1, 0, 7); // before the others so replay does not start early
    for (int e = 0; e < 7; e++) begin
      add_row(t, OP_REFILL, 2 + e, 0, e);
    end
    for (int e = 0; e < 7; e++) begin
      add_row(t, OP_READ, 2 + e, 0, e % 2);
    end
    add_tail(t);
    t = "buffer_full";
    for (int c = 0; c < 5; c++) begin
      add_row(t, OP_FILL, 10 + 2 * c, 11 + 2 * c, 0);
    end
    add_idle(t, 1);
    add_row(t, OP_FLAGS, 0, 0, 1);
    for (int e = 0; e < 8; e++) begin
      add_row(t, OP_REFILL, 10 + e, 0, e);
    end
    for (int e = 0; e < 8; e++) begin
      add_row(t, OP_READ, 10 + e, 0, e % 2);
    end
    add_tail(t);
    t = "unlock";
    add_row(t, OP_FLAGS, 0, 0, 2);
    add_row(t, OP_FILL, -1, 20, 0);
    add_idle(t, 2);
    add_row(t, OP_REFILL, 20, 0, 0);
    add_row(t, OP_READ, 20, 0, 1);
    add_tail(t);
  endtask

  task automatic clear_inputs();
    fill_en_i   = '0;
    fill_addr_i = '0;
    fill_st_i   = '0;
    fill_sz_i   = '0;
    ins_en_i    = 1'b0;
    ins_idx_i   = '0;
    unlock_i    = 1'b0;
  endtask

  task automatic drive_port(input int p, input int k);
    if (k >= 0) begin
      fill_en_i[p]   = 1'b1;
      fill_addr_i[p] = addr_pool[k];
      fill_st_i[p]   = st_pool[k][p];
      fill_sz_i[p]   = sz_pool[k][p];
    end
  endtask

  task automatic wait_for(input string name, input bit on_read, input logic level);
    int t;
    t = 0;
    while (t < WAIT_LIMIT && (on_read ? read_en_o : begin_replay_o) !== level) begin
      @(negedge clk);
      t++;
    end
    if ((on_read ? read_en_o : begin_replay_o) !== level) begin
      $display("%s: timed out waiting for %s to go to %0b", name,
               on_read ? "read_en_o" : "begin_replay_o", level);
      timed_out = 1'b1;
    end
  endtask

  task automatic apply_row(input int i);
    int k;
    int arg;
    k   = row_a0[i];
    arg = row_arg[i];
    case (row_op[i])
      OP_READ: chk.expect_read(row_name[i], addr_pool[k], st_pool[k][arg], sz_pool[k][arg]);
      OP_END:  chk.end_test(row_name[i]);
      default: begin
        @(negedge clk);
        clear_inputs();
        case (row_op[i])
          OP_FILL: begin
            drive_port(0, k);
            drive_port(1, row_a1[i]);
          end
          OP_REFILL: begin
            ins_en_i  = 1'b1;
            ins_idx_i = dmiss_pkg::entry_idx_t'(arg);
            chk.expect_refill(row_name[i], k < 0 ? dmiss_pkg::line_addr_t'(0) : addr_pool[k]);
          end
          OP_FLAGS:  chk.check_flags(row_name[i], arg[1], arg[0]);
          OP_UNLOCK: unlock_i = 1'b1;
          OP_REPLAY: begin
            wait_for(row_name[i], 1'b0, 1'b1);
            if (!timed_out) wait_for(row_name[i], 1'b1, 1'b1);
            if (!timed_out) wait_for(row_name[i], 1'b1, 1'b0);
          end
          default: ; // idle cycle
        endcase
      end
    endcase
  endtask

  initial begin
    logic [31:0] seed;
    logic [31:0] r1;
    logic [31:0] r2;
    int          i;
    clk       = 1'b0;
    rst       = 1'b1;
    timed_out = 1'b0;
    clear_inputs();
    seed = 32'd67;
    for (int k = 0; k < POOL_SIZE; k++) begin
      seed = lcg_next(seed);
      r1   = seed;
      seed = lcg_next(seed);
      r2   = seed;
      addr_pool[k]  = dmiss_pkg::line_addr_t'({1'b1, r2[31:29], r1}); // top bit keeps it nonzero
      st_pool[k][0] = r2[16];
      st_pool[k][1] = ~r2[16];
      sz_pool[k][0] = dmiss_pkg::op_size_t'(r2[28:24]);
      sz_pool[k][1] = ~dmiss_pkg::op_size_t'(r2[28:24]);
    end
    build_table();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    i = 0;
    while (i < row_op.size() && !timed_out) begin
      apply_row(i);
      i++;
    end
    chk.report();
    if (timed_out || chk.err_count != 0) begin
      $display("Test FAILED");
    end else begin
      $display("Test OK");
    end
    $finish;
  end

endmodule

// ==== bench/dmiss_checker.sv ====
`timescale 1ns/1ps
`include "dmiss_settings.svh"

module dmiss_checker (
  input logic                  clk,
  input logic                  rst,
  input logic                  ins_en_i,
  input dmiss_pkg::line_addr_t ins_addr_i,
  input logic                  has_free_i,
  input logic                  locked_i,
  input logic                  begin_replay_i,
  input logic                  read_en_i,
  input dmiss_pkg::line_addr_t read_addr_i,
  input logic                  read_st_i,
  input dmiss_pkg::op_size_t   read_sz_i
);

  int    err_count    = 0;
  int    test_errs    = 0;
  int    tests_passed = 0;
  int    tests_failed = 0;
  string cur_test     = "reset";
  logic  replay_last  = 1'b0; // begin_replay at the previous edge

  dmiss_pkg::line_addr_t ref_q     [$]; // refill lookups in the order they are driven
  dmiss_pkg::line_addr_t rd_addr_q [$]; // readout in the order it must appear
  logic                  rd_st_q   [$];
  dmiss_pkg::op_size_t   rd_sz_q   [$];

  task automatic report_problem(input string msg);
    $display("%s: %s", cur_test, msg);
    test_errs++;
    err_count++;
  endtask

  task automatic compare(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: %s expected %0h, actual %0h", cur_test, what, expected, actual);
      test_errs++;
      err_count++;
    end
  endtask

  task automatic expect_refill(input string name, input dmiss_pkg::line_addr_t addr);
    cur_test = name;
    ref_q.push_back(addr);
  endtask

  task automatic expect_read(input string name, input dmiss_pkg::line_addr_t addr,
                             input logic st, input dmiss_pkg::op_size_t sz);
    cur_test = name;
    rd_addr_q.push_back(addr);
    rd_st_q.push_back(st);
    rd_sz_q.push_back(sz);
  endtask

  task automatic check_flags(input string name, input logic free, input logic locked);
    cur_test = name;
    compare("has_free_o", 64'(free), 64'(has_free_i));
    compare("locked_o", 64'(locked), 64'(locked_i));
  endtask

  // sampled at the rising edge, where the falling-edge stimulus has settled
  always @(posedge clk) begin
    if (!rst) begin
      if (ins_en_i && ref_q.size() == 0) begin
        report_problem("refill lookup without an expected address");
      end else if (ins_en_i) begin
        compare("ins_addr_o", 64'(ref_q.pop_front()), 64'(ins_addr_i));
      end
      if (read_en_i && rd_addr_q.size() == 0) begin
        report_problem($sformatf("unexpected read of line %0h", read_addr_i));
      end else if (read_en_i) begin
        compare("read_addr_o", 64'(rd_addr_q.pop_front()), 64'(read_addr_i));
        compare("read_st_o", 64'(rd_st_q.pop_front()), 64'(read_st_i));
        compare("read_sz_o", 64'(rd_sz_q.pop_front()), 64'(read_sz_i));
      end
      if (begin_replay_i && replay_last) begin
        report_problem("begin_replay_o stayed high for more than one cycle");
      end
      replay_last <= begin_replay_i;
    end
  end

  task automatic end_test(input string name);
    cur_test = name;
    if (ref_q.size() != 0) begin
      report_problem($sformatf("%0d refill lookups were never made", ref_q.size()));
    end
    if (rd_addr_q.size() != 0) begin
      report_problem($sformatf("%0d expected reads never came out", rd_addr_q.size()));
    end
    if (test_errs == 0) begin
      $display("PASS %s", name);
      tests_passed++;
    end else begin
      $display("FAIL %s with %0d errors", name, test_errs);
      tests_failed++;
    end
    test_errs = 0;
    ref_q.delete();
    rd_addr_q.delete();
    rd_st_q.delete();
    rd_sz_q.delete();
  endtask

  task automatic report();
    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, err_count);
  endtask

endmodule

// ==== verilog/dmiss_cam_top.sv ====
`timescale 1ns/1ps
`include "dmiss_settings.svh"

module dmiss_cam_top (
  input  logic                                     clk,
  input  logic                                     rst,
  input  dmiss_pkg::port_mask_t                    fill_en_i,
  input  dmiss_pkg::line_addr_t [`DMISS_PORTS-1:0] fill_addr_i,
  input  dmiss_pkg::port_mask_t                    fill_st_i,
  input  dmiss_pkg::op_size_t   [`DMISS_PORTS-1:0] fill_sz_i,
  input  logic                                     ins_en_i,
  input  dmiss_pkg::entry_idx_t                    ins_idx_i,
  input  logic                                     unlock_i,
  output dmiss_pkg::line_addr_t                    ins_addr_o,
  output logic                                     has_free_o,
  output logic                                     locked_o,
  output logic                                     begin_replay_o,
  output logic                                     read_en_o,
  output dmiss_pkg::line_addr_t                    read_addr_o,
  output logic                                     read_st_o,
  output dmiss_pkg::op_size_t                      read_sz_o
);

  fill_req_if req_bus ();
  entry_if    ent_bus ();

  dmiss_port_filter u_filter (
    .clk         (clk),
    .rst         (rst),
    .fill_en_i   (fill_en_i),
    .fill_addr_i (fill_addr_i),
    .fill_st_i   (fill_st_i),
    .fill_sz_i   (fill_sz_i),
    .locked_i    (locked_o),
    .req         (req_bus.filter),
    .ent         (ent_bus.lookup)
  );

  // misses dropped for lack of a free entry simply vanish
  dmiss_alloc u_alloc (
    .req    (req_bus.alloc),
    .ent    (ent_bus.alloc),
    .lost_o ()
  );

  dmiss_entries u_entries (
    .clk        (clk),
    .rst        (rst),
    .req_addr_i (req_bus.addr),
    .req_st_i   (req_bus.st),
    .req_sz_i   (req_bus.sz),
    .ins_en_i   (ins_en_i),
    .ins_idx_i  (ins_idx_i),
    .unlock_i   (unlock_i),
    .ins_addr_o (ins_addr_o),
    .ent        (ent_bus.owner)
  );

  dmiss_replay u_replay (
    .clk            (clk),
    .rst            (rst),
    .unlock_i       (unlock_i),
    .ent            (ent_bus.replay),
    .begin_replay_o (begin_replay_o),
    .locked_o       (locked_o),
    .has_free_o     (has_free_o),
    .read_en_o      (read_en_o),
    .read_addr_o    (read_addr_o),
    .read_st_o      (read_st_o),
    .read_sz_o      (read_sz_o)
  );

endmodule

// ==== verilog/dmiss_replay.sv ====
`timescale 1ns/1ps
`include "dmiss_settings.svh"

module dmiss_replay (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  unlock_i,
  entry_if.replay               ent,
  output logic                  begin_replay_o,
  output logic                  locked_o,
  output logic                  has_free_o,
  output logic                  read_en_o,
  output dmiss_pkg::line_addr_t read_addr_o,
  output logic                  read_st_o,
  output dmiss_pkg::op_size_t   read_sz_o
);

  dmiss_pkg::replay_state_t state;
  dmiss_pkg::replay_state_t state_nxt;
  dmiss_pkg::entry_mask_t   read_mask; // entries already replayed
  dmiss_pkg::entry_mask_t   unread;
  dmiss_pkg::entry_idx_t    sel_idx;   // lowest busy entry not yet read
  logic                     last_read;

  assign has_free_o     = ~&ent.busy;
  assign begin_replay_o = state == dmiss_pkg::RS_WAIT && ent.pending == '0;
  assign unread         = ent.busy & ~read_mask;
  assign read_en_o      = state == dmiss_pkg::RS_REPLAY && unread != '0;
  assign last_read      = unread == (dmiss_pkg::entry_mask_t'(1) << sel_idx);

  always_comb begin
    sel_idx = '0;
    for (int e = `DMISS_ENTRIES - 1; e >= 0; e--) begin
      if (unread[e]) begin
        sel_idx = dmiss_pkg::entry_idx_t'(e);
      end
    end
  end

  assign read_addr_o = read_en_o ? ent.addr[sel_idx] : '0;
  assign read_st_o   = read_en_o && ent.st[sel_idx];
  assign read_sz_o   = read_en_o ? ent.sz[sel_idx] : '0;

  always_comb begin
    state_nxt = state;
    case (state)
      dmiss_pkg::RS_IDLE:   if (ent.busy != '0) state_nxt = dmiss_pkg::RS_WAIT;
      dmiss_pkg::RS_WAIT:   if (begin_replay_o) state_nxt = dmiss_pkg::RS_REPLAY;
      dmiss_pkg::RS_REPLAY: if (!read_en_o || last_read) state_nxt = dmiss_pkg::RS_HOLD;
      default:              state_nxt = state; // hold until unlock
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst || unlock_i) begin
      state     <= dmiss_pkg::RS_IDLE;
      read_mask <= '0;
      locked_o  <= 1'b0;
    end else begin
      state <= state_nxt;
      if (read_en_o) begin
        read_mask <= read_mask | (dmiss_pkg::entry_mask_t'(1) << sel_idx);
      end
      if (!has_free_o || begin_replay_o) begin
        locked_o <= 1'b1;
      end
    end
  end

  // an entry is only replayed once its refill has arrived
  a_read_refilled: assert property (
    @(posedge clk) disable iff (rst)
    read_en_o |-> !ent.pending[sel_idx]
  );

endmodule

// ==== verilog/dmiss_entries.sv ====
`timescale 1ns/1ps
`include "dmiss_settings.svh"

module dmiss_entries (
  input  logic                                     clk,
  input  logic                                     rst,
  input  dmiss_pkg::line_addr_t [`DMISS_PORTS-1:0] req_addr_i,
  input  dmiss_pkg::port_mask_t                    req_st_i,
  input  dmiss_pkg::op_size_t   [`DMISS_PORTS-1:0] req_sz_i,
  input  logic                                     ins_en_i,
  input  dmiss_pkg::entry_idx_t                    ins_idx_i,
  input  logic                                     unlock_i,
  output dmiss_pkg::line_addr_t                    ins_addr_o,
  entry_if.owner                                   ent
);

  dmiss_pkg::entry_mask_t refill_mask; // entry whose refill arrives this cycle

  assign refill_mask = ins_en_i ? (dmiss_pkg::entry_mask_t'(1) << ins_idx_i) : '0;

  // refill lookup, zero when the tag names an idle entry
  assign ins_addr_o = (ins_en_i && ent.busy[ins_idx_i]) ? ent.addr[ins_idx_i] : '0;

  always_ff @(posedge clk) begin
    if (rst || unlock_i) begin
      ent.busy    <= '0;
      ent.pending <= '0;
    end else begin
      ent.busy    <= ent.busy | ent.wr_mask;
      ent.pending <= (ent.pending & ~refill_mask) | ent.wr_mask;
    end
  end

  // payload follows the one-hot port select of each written entry
  always_ff @(posedge clk) begin
    for (int e = 0; e < `DMISS_ENTRIES; e++) begin
      for (int p = 0; p < `DMISS_PORTS; p++) begin
        if (ent.wr_mask[e] && ent.wr_port[e][p]) begin
          ent.addr[e] <= req_addr_i[p];
          ent.st[e]   <= req_st_i[p];
          ent.sz[e]   <= req_sz_i[p];
        end
      end
    end
  end

  // an entry can only wait for a refill while it is allocated
  a_pending_busy: assert property (
    @(posedge clk) disable iff (rst)
    (ent.pending & ~ent.busy) == '0
  );

endmodule

// ==== verilog/dmiss_alloc.sv ====
`timescale 1ns/1ps
`include "dmiss_settings.svh"

module dmiss_alloc (
  fill_req_if.alloc             req,
  entry_if.alloc                ent,
  output dmiss_pkg::port_mask_t lost_o
);

  always_comb begin
    dmiss_pkg::entry_mask_t taken;
    logic                   placed;

    taken       = ent.busy; // free entries are handed out as slots claim them
    ent.wr_mask = '0;
    ent.wr_port = '0;
    lost_o      = '0;

    for (int p = 0; p < `DMISS_PORTS; p++) begin
      placed = 1'b0;
      for (int e = 0; e < `DMISS_ENTRIES; e++) begin
        if (req.valid[p] && !placed && !taken[e]) begin
          taken[e]          = 1'b1;
          ent.wr_mask[e]    = 1'b1;
          ent.wr_port[e][p] = 1'b1;
          placed            = 1'b1;
        end
      end
      lost_o[p] = req.valid[p] && !placed; // buffer full, the miss is dropped
    end

    // every staged miss either lands in an idle entry or is counted as lost
    a_wr_idle: assert ((ent.wr_mask & ent.busy) == '0 &&
                       $countones(ent.wr_mask) + $countones(lost_o) ==
                       $countones(req.valid));
  end

endmodule

// ==== verilog/dmiss_port_filter.sv ====
`timescale 1ns/1ps
`include "dmiss_settings.svh"

module dmiss_port_filter (
  input  logic                                     clk,
  input  logic                                     rst,
  input  dmiss_pkg::port_mask_t                    fill_en_i,
  input  dmiss_pkg::line_addr_t [`DMISS_PORTS-1:0] fill_addr_i,
  input  dmiss_pkg::port_mask_t                    fill_st_i,
  input  dmiss_pkg::op_size_t   [`DMISS_PORTS-1:0] fill_sz_i,
  input  logic                                     locked_i,
  fill_req_if.filter                               req,
  entry_if.lookup                                  ent
);

  dmiss_pkg::port_mask_t keep;       // misses that survive the merge this cycle
  logic                  staged_dup; // two valid staged slots with one address

  always_comb begin
    for (int p = 0; p < `DMISS_PORTS; p++) begin
      keep[p] = fill_en_i[p] && !locked_i;

      // the highest-numbered port carrying an address keeps it
      for (int q = p + 1; q < `DMISS_PORTS; q++) begin
        if (fill_en_i[q] && fill_addr_i[q] == fill_addr_i[p]) begin
          keep[p] = 1'b0;
        end
      end

      // staged slots are not visible in the entries until the next edge
      for (int q = 0; q < `DMISS_PORTS; q++) begin
        if (req.valid[q] && req.addr[q] == fill_addr_i[p]) begin
          keep[p] = 1'b0;
        end
      end

      for (int e = 0; e < `DMISS_ENTRIES; e++) begin
        if (ent.busy[e] && ent.addr[e] == fill_addr_i[p]) begin
          keep[p] = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      req.valid <= '0;
    end else begin
      req.valid <= keep;
    end
  end

  always_ff @(posedge clk) begin
    req.addr <= fill_addr_i;
    req.st   <= fill_st_i;
    req.sz   <= fill_sz_i;
  end

  always_comb begin
    staged_dup = 1'b0;
    for (int p = 0; p < `DMISS_PORTS; p++) begin
      for (int q = p + 1; q < `DMISS_PORTS; q++) begin
        if (req.valid[p] && req.valid[q] && req.addr[p] == req.addr[q]) begin
          staged_dup = 1'b1;
        end
      end
    end
  end

  // the merge one cycle earlier must leave at most one slot per address
  a_no_staged_dup: assert property (@(posedge clk) disable iff (rst) !staged_dup);

endmodule

// ==== verilog/dmiss_ifs.sv ====
`timescale 1ns/1ps
`include "dmiss_settings.svh"

// staged misses, one slot per fill port
interface fill_req_if;
  dmiss_pkg::port_mask_t                       valid; // slot holds a new miss this cycle
  dmiss_pkg::line_addr_t [`DMISS_PORTS-1:0]    addr;
  dmiss_pkg::port_mask_t                       st;    // store flag per slot
  dmiss_pkg::op_size_t   [`DMISS_PORTS-1:0]    sz;

  modport filter (
    output valid,
    output addr,
    output st,
    output sz
  );

  modport alloc (
    input valid
  );
endinterface

// entry state plus the write strobes that fill it
interface entry_if;
  dmiss_pkg::entry_mask_t                      busy;
  dmiss_pkg::entry_mask_t                      pending; // still waiting for its refill
  dmiss_pkg::line_addr_t [`DMISS_ENTRIES-1:0]  addr;
  dmiss_pkg::entry_mask_t                      st;
  dmiss_pkg::op_size_t   [`DMISS_ENTRIES-1:0]  sz;
  dmiss_pkg::entry_mask_t                      wr_mask; // entry gets written at the next edge
  dmiss_pkg::port_mask_t [`DMISS_ENTRIES-1:0]  wr_port; // one-hot source slot per entry

  modport owner (output busy, output pending, output addr, output st, output sz,
                 input wr_mask, input wr_port);

  modport alloc (input busy, output wr_mask, output wr_port);

  modport lookup (input busy, input addr);

  modport replay (input busy, input pending, input addr, input st, input sz);
endinterface

// ==== verilog/dmiss_pkg.sv ====
`include "dmiss_settings.svh"

package dmiss_pkg;

  typedef logic [`DMISS_LINE_W-1:0] line_addr_t; // line address of a miss

  typedef logic [`DMISS_SZ_W-1:0] op_size_t;

  typedef logic [`DMISS_IDX_W-1:0] entry_idx_t; // entry number, also the refill tag

  typedef logic [`DMISS_ENTRIES-1:0] entry_mask_t; // one bit per entry

  typedef logic [`DMISS_PORTS-1:0] port_mask_t; // one bit per fill port

  typedef enum logic [1:0] {
    RS_IDLE,   // buffer empty
    RS_WAIT,   // misses outstanding, waiting for refills
    RS_REPLAY, // reading out busy entries
    RS_HOLD    // readout done, waiting for unlock
  } replay_state_t;

endpackage

// ==== include/dmiss_settings.svh ====
`ifndef DMISS_SETTINGS_SVH
`define DMISS_SETTINGS_SVH

// number of fill ports that can report a miss in the same cycle
`define DMISS_PORTS 2

// number of miss buffer entries
`define DMISS_ENTRIES 8

// cache-line address width, byte offset already stripped
`define DMISS_LINE_W 36

`define DMISS_SZ_W 5 // access size code

`define DMISS_IDX_W 3 // must cover DMISS_ENTRIES

`endif
